//--- rtl/obstacle_pkg.sv
package obstacle_pkg;

    // raw word from the track generator
    // [15:13] kind, [12:11] lane, [10:0] depth of the far end
    typedef logic [15:0] obstacle_word_t;

    typedef enum logic [2:0] {
        kind_none           = 3'd0,
        kind_low_barrier    = 3'd1,  // jump over
        kind_high_barrier   = 3'd2,  // duck under
        kind_middle_barrier = 3'd3,  // either
        kind_train_car      = 3'd4,
        kind_ramp           = 3'd5   // not drawn
    } obstacle_kind_t;

    typedef logic [1:0] lane_t;

    // unsigned, far end of the obstacle
    typedef logic [10:0] depth_t;

    localparam int KIND_LSB = 13;
    localparam int LANE_LSB = 11;

endpackage

//--- rtl/scene_pkg.sv
package scene_pkg;

    typedef logic signed [15:0] coord_t;

    // {x, y, z}
    typedef logic [47:0] vertex_t;

    typedef logic [15:0] color_t;

    typedef enum logic [1:0] {
        shape_low_board,
        shape_high_board,
        shape_mid_board,
        shape_car
    } shape_t;

    typedef enum logic [1:0] {
        x_left,
        x_right,
        x_left_peg,   // left edge plus peg width
        x_right_peg   // right edge minus peg width
    } x_sel_t;

    typedef enum logic [2:0] {
        y_ground,
        y_mid,
        y_top,
        y_mid_up,     // mid minus band
        y_mid_down    // mid plus band
    } y_sel_t;

    typedef logic [4:0] vertex_index_t;

    // screen y grows downward
    localparam coord_t GROUND   = 16'sd128;
    localparam coord_t MID      = 16'sd96;
    localparam coord_t TOP      = 16'sd64;
    localparam coord_t MID_BAND = 16'sd8;

    localparam coord_t BARRIER_SETBACK = 16'sd32;
    localparam coord_t CAR_LENGTH      = 16'sd128;

    localparam coord_t LEFT_LANE_LEFT    = -16'sd128;
    localparam coord_t LEFT_LANE_RIGHT   = -16'sd64;
    localparam coord_t MIDDLE_LANE_LEFT  = -16'sd32;
    localparam coord_t MIDDLE_LANE_RIGHT = 16'sd32;
    localparam coord_t RIGHT_LANE_LEFT   = 16'sd64;
    localparam coord_t RIGHT_LANE_RIGHT  = 16'sd128;

    localparam color_t COLOR_LOW       = 16'hF000;  // red
    localparam color_t COLOR_HIGH      = 16'hFE18;  // pink
    localparam color_t COLOR_MID       = 16'hFD00;  // orange
    localparam color_t COLOR_CAR_FRONT = 16'h001F;
    localparam color_t COLOR_CAR_LEFT  = 16'h000F;
    localparam color_t COLOR_CAR_RIGHT = 16'h000A;
    localparam color_t COLOR_CAR_TOP   = 16'h312F;

endpackage

//--- rtl/obstacle_decoder.sv
`timescale 1ns/1ps

module obstacle_decoder #(
    parameter int MIN_Z = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  obstacle_pkg::obstacle_word_t  obstacle,
    input  logic                          obstacle_valid,
    input  logic                          busy,
    output logic                          start,
    output scene_pkg::shape_t             shape,
    output scene_pkg::coord_t             lane_left,
    output scene_pkg::coord_t             lane_right,
    output scene_pkg::coord_t             depth
);
    import obstacle_pkg::*;
    import scene_pkg::*;

    obstacle_kind_t kind;
    lane_t          lane;
    depth_t         raw_depth;
    coord_t         word_depth;
    coord_t         word_left;
    coord_t         word_right;
    shape_t         word_shape;
    logic           kept;
    logic           culled;
    logic           accept;
    logic           launch;

    assign kind       = obstacle_kind_t'(obstacle[KIND_LSB +: $bits(obstacle_kind_t)]);
    assign lane       = obstacle[LANE_LSB +: $bits(lane_t)];
    assign raw_depth  = obstacle[0 +: $bits(depth_t)];
    assign word_depth = coord_t'({5'd0, raw_depth});

    always_comb begin
        word_shape = shape_low_board;
        kept = 1'b1;
        case (kind)
            kind_low_barrier:    word_shape = shape_low_board;
            kind_high_barrier:   word_shape = shape_high_board;
            kind_middle_barrier: word_shape = shape_mid_board;
            kind_train_car:      word_shape = shape_car;
            kind_none, kind_ramp: kept = 1'b0;
            default:             kept = 1'b0;  // codes 6, 7
        endcase
    end

    always_comb begin
        case (lane)
            2'd0: begin
                word_left  = LEFT_LANE_LEFT;
                word_right = LEFT_LANE_RIGHT;
            end
            2'd1: begin
                word_left  = MIDDLE_LANE_LEFT;
                word_right = MIDDLE_LANE_RIGHT;
            end
            default: begin  // lane 3 folds onto the right lane
                word_left  = RIGHT_LANE_LEFT;
                word_right = RIGHT_LANE_RIGHT;
            end
        endcase
    end

    // barrier face would sit behind the camera
    assign culled = (word_shape != shape_car) && (word_depth < BARRIER_SETBACK + coord_t'(MIN_Z));
    assign accept = obstacle_valid && !busy && !start;
    assign launch = accept && kept && !culled;

    always_ff @(posedge clk) begin
        if (rst) begin
            start <= 1'b0;
        end else begin
            start <= launch;
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            shape      <= word_shape;
            lane_left  <= word_left;
            lane_right <= word_right;
            depth      <= word_depth;
        end
    end

    a_no_start_while_busy: assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule

//--- rtl/shape_table.sv
`timescale 1ns/1ps

module shape_table (
    input  scene_pkg::shape_t         shape,
    input  scene_pkg::vertex_index_t  index,
    output scene_pkg::x_sel_t         x_sel,
    output scene_pkg::y_sel_t         y_sel,
    output logic                      z_far,
    output scene_pkg::color_t         color,
    output logic                      color_load,
    output logic                      last
);
    import scene_pkg::*;

    y_sel_t face_low;
    y_sel_t face_high;
    color_t board_color;

    // the three boards share one walk, only the face band differs
    always_comb begin
        case (shape)
            shape_high_board: begin
                face_low    = y_mid;
                face_high   = y_top;
                board_color = COLOR_HIGH;
            end
            shape_mid_board: begin
                face_low    = y_mid_up;
                face_high   = y_mid_down;
                board_color = COLOR_MID;
            end
            default: begin
                face_low    = y_ground;
                face_high   = y_mid;
                board_color = COLOR_LOW;
            end
        endcase
    end

    always_comb begin
        x_sel      = x_left;
        y_sel      = y_ground;
        z_far      = 1'b0;
        color      = board_color;
        color_load = (index == 5'd0);
        last       = 1'b0;

        if (shape == shape_car) begin
            // front 0-5, left side 6-11, right side 12-17, roof 18-23
            case (index)
                5'd1, 5'd3, 5'd4, 5'd12, 5'd13, 5'd14,
                5'd15, 5'd16, 5'd17, 5'd19, 5'd20, 5'd21: x_sel = x_right;
                default: x_sel = x_left;
            endcase

            case (index)
                5'd0, 5'd1, 5'd3, 5'd6, 5'd8,
                5'd11, 5'd14, 5'd15, 5'd17: y_sel = y_ground;
                default: y_sel = y_top;
            endcase

            case (index)
                5'd8, 5'd10, 5'd11, 5'd13, 5'd16,
                5'd17, 5'd20, 5'd21, 5'd22: z_far = 1'b1;
                default: z_far = 1'b0;
            endcase

            if (index < 5'd6) begin
                color = COLOR_CAR_FRONT;
            end else if (index < 5'd12) begin
                color = COLOR_CAR_LEFT;
            end else if (index < 5'd18) begin
                color = COLOR_CAR_RIGHT;
            end else begin
                color = COLOR_CAR_TOP;
            end

            color_load = index inside {5'd0, 5'd6, 5'd12, 5'd18};
            last       = (index == 5'd23);
        end else begin
            // face 0-5, left peg 6-11, right peg 12-17
            case (index)
                5'd1, 5'd3, 5'd4, 5'd14, 5'd15, 5'd17: x_sel = x_right;
                5'd8, 5'd9, 5'd10:                     x_sel = x_left_peg;
                5'd12, 5'd13, 5'd16:                   x_sel = x_right_peg;
                default:                               x_sel = x_left;
            endcase

            case (index)
                5'd0, 5'd1, 5'd3:                       y_sel = face_low;
                5'd2, 5'd4, 5'd5:                       y_sel = face_high;
                5'd6, 5'd10, 5'd11, 5'd12, 5'd14, 5'd15: y_sel = y_mid;
                default:                                y_sel = y_ground;
            endcase

            // low barrier is the face only
            last = (shape == shape_low_board) ? (index == 5'd5) : (index == 5'd17);
        end
    end

endmodule

//--- rtl/vertex_sequencer.sv
`timescale 1ns/1ps

module vertex_sequencer #(
    parameter int MIN_Z     = 8,
    parameter int PEG_WIDTH = 10
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  scene_pkg::shape_t  shape,
    input  scene_pkg::coord_t  lane_left,
    input  scene_pkg::coord_t  lane_right,
    input  scene_pkg::coord_t  depth,
    input  logic               done_in,
    output logic               busy,
    output scene_pkg::vertex_t vertex,
    output scene_pkg::color_t  color,
    output logic               new_triangle,
    output logic               done_out
);
    import scene_pkg::*;

    vertex_index_t index;
    logic [1:0]    corner;  // position within the current triangle
    x_sel_t        x_sel;
    y_sel_t        y_sel;
    logic          z_far;
    color_t        table_color;
    logic          color_load;
    logic          last;
    coord_t        x;
    coord_t        y;
    coord_t        z_raw;
    coord_t        z;

    shape_table i_shape_table (
        .shape      (shape),
        .index      (index),
        .x_sel      (x_sel),
        .y_sel      (y_sel),
        .z_far      (z_far),
        .color      (table_color),
        .color_load (color_load),
        .last       (last)
    );

    always_comb begin
        case (x_sel)
            x_left:     x = lane_left;
            x_right:    x = lane_right;
            x_left_peg: x = lane_left + coord_t'(PEG_WIDTH);
            default:    x = lane_right - coord_t'(PEG_WIDTH);
        endcase
    end

    always_comb begin
        case (y_sel)
            y_ground:   y = GROUND;
            y_mid:      y = MID;
            y_top:      y = TOP;
            y_mid_up:   y = MID - MID_BAND;
            y_mid_down: y = MID + MID_BAND;
            default:    y = GROUND;
        endcase
    end

    // near plane sits a setback in front of a board, a car length for the car
    assign z_raw = z_far ? depth : depth - ((shape == shape_car) ? CAR_LENGTH : BARRIER_SETBACK);
    assign z     = (z_raw < coord_t'(MIN_Z)) ? coord_t'(MIN_Z) : z_raw;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy         <= 1'b0;
            index        <= '0;
            corner       <= '0;
            new_triangle <= 1'b0;
            done_out     <= 1'b0;
        end else begin
            new_triangle <= busy && (corner == 2'd0);
            done_out     <= done_in && !busy && !start;  // relay only while idle
            if (start) begin
                busy   <= 1'b1;
                index  <= '0;
                corner <= '0;
            end else if (busy) begin
                corner <= (corner == 2'd2) ? 2'd0 : corner + 2'd1;
                if (last) begin
                    busy <= 1'b0;
                end else begin
                    index <= index + 5'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            vertex <= {x, y, z};
            if (color_load) begin
                color <= table_color;
            end
        end
    end

    a_triangle_with_vertex: assert property (@(posedge clk) disable iff (rst)
        new_triangle |-> $past(busy) && ($past(index) % 3 == 0));

    a_index_in_range: assert property (@(posedge clk) disable iff (rst) index <= 5'd23);

endmodule

//--- rtl/triangle_creator.sv
`timescale 1ns/1ps

module triangle_creator #(
    parameter int MIN_Z     = 8,
    parameter int PEG_WIDTH = 10
) (
    input  logic                         clk,
    input  logic                         rst,
    input  obstacle_pkg::obstacle_word_t obstacle,
    input  logic                         obstacle_valid,
    input  logic                         done_in,
    output scene_pkg::vertex_t           vertex,
    output scene_pkg::color_t            color,
    output logic                         new_triangle,
    output logic                         done_out
);
    import scene_pkg::*;

    logic   start;
    logic   busy;
    shape_t shape;
    coord_t lane_left;
    coord_t lane_right;
    coord_t depth;

    obstacle_decoder #(
        .MIN_Z (MIN_Z)
    ) i_obstacle_decoder (
        .clk            (clk),
        .rst            (rst),
        .obstacle       (obstacle),
        .obstacle_valid (obstacle_valid),
        .busy           (busy),
        .start          (start),
        .shape          (shape),
        .lane_left      (lane_left),
        .lane_right     (lane_right),
        .depth          (depth)
    );

    vertex_sequencer #(
        .MIN_Z     (MIN_Z),
        .PEG_WIDTH (PEG_WIDTH)
    ) i_vertex_sequencer (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .shape        (shape),
        .lane_left    (lane_left),
        .lane_right   (lane_right),
        .depth        (depth),
        .done_in      (done_in),
        .busy         (busy),
        .vertex       (vertex),
        .color        (color),
        .new_triangle (new_triangle),
        .done_out     (done_out)
    );

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    // held over four rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- tb/tb_checker.sv
`timescale 1ns/1ps

module tb_checker #(
    parameter int MIN_Z     = 8,
    parameter int PEG_WIDTH = 10
) (
    input logic        clk,
    input logic        rst,
    input logic [15:0] obstacle,
    input logic        obstacle_valid,
    input logic        done_in,
    input logic [47:0] vertex,
    input logic [15:0] color,
    input logic        new_triangle,
    input logic        done_out
);
    // one bit per vertex index, in walk order
    localparam logic [23:0] CAR_RIGHT       = 24'h3BF01A;
    localparam logic [23:0] CAR_GROUND      = 24'h02C94B;
    localparam logic [23:0] CAR_FAR         = 24'h732D00;
    localparam logic [17:0] BOARD_RIGHT     = 18'h2C01A;
    localparam logic [17:0] BOARD_LEFT_PEG  = 18'h00700;
    localparam logic [17:0] BOARD_RIGHT_PEG = 18'h13000;
    localparam logic [17:0] BOARD_FACE_LOW  = 18'h0000B;
    localparam logic [17:0] BOARD_FACE_HIGH = 18'h00034;
    localparam logic [17:0] BOARD_MID       = 18'h0DC40;

    logic [47:0] exp_vertices[$];
    logic [15:0] exp_colors[$];
    logic [47:0] exp_vertex;
    logic [15:0] exp_color;
    logic [47:0] last_vertex;
    logic [15:0] last_color;
    logic [15:0] cur_word;
    logic        exp_tri;
    logic        exp_done;
    logic        emit;
    logic        accept;
    logic        m_start;
    logic        m_busy;
    logic        live = 1'b0;
    int          m_index;
    int          error_count = 0;
    int          check_count = 0;
    int          test_count = 0;
    int          test_errors = 0;
    int          test_checks = 0;

    function automatic int shape_length(input logic [15:0] word);
        int kind;
        int depth;
        kind  = word[15:13];
        depth = word[10:0];
        if (kind == 4) return 24;
        if (kind < 1 || kind > 3) return 0;     // no obstacle
        if (depth < 32 + MIN_Z) return 0;       // culled barrier
        return (kind == 1) ? 6 : 18;
    endfunction

    function automatic int clamp_z(input int z);
        return (z < MIN_Z) ? MIN_Z : z;
    endfunction

    function automatic void build_reference(input logic [15:0] word);
        int          kind;
        int          lane;
        int          depth;
        int          left;
        int          right;
        int          face_lo;
        int          face_hi;
        int          x;
        int          y;
        int          z;
        logic [15:0] board_color;
        logic [15:0] col;
        kind  = word[15:13];
        lane  = word[12:11];
        depth = word[10:0];
        case (lane)
            0:       begin left = -128; right = -64; end
            1:       begin left = -32;  right = 32;  end
            default: begin left = 64;   right = 128; end
        endcase
        case (kind)
            2:       begin face_lo = 96;  face_hi = 64;  board_color = 16'hFE18; end
            3:       begin face_lo = 88;  face_hi = 104; board_color = 16'hFD00; end
            default: begin face_lo = 128; face_hi = 96;  board_color = 16'hF000; end
        endcase
        for (int i = 0; i < shape_length(word); i++) begin
            if (kind == 4) begin
                x = CAR_RIGHT[i] ? right : left;
                y = CAR_GROUND[i] ? 128 : 64;
                z = clamp_z(CAR_FAR[i] ? depth : depth - 128);
                case (i / 6)
                    0:       col = 16'h001F;  // front
                    1:       col = 16'h000F;
                    2:       col = 16'h000A;
                    default: col = 16'h312F;  // roof
                endcase
            end else begin
                if (BOARD_RIGHT[i]) x = right;
                else if (BOARD_LEFT_PEG[i]) x = left + PEG_WIDTH;
                else if (BOARD_RIGHT_PEG[i]) x = right - PEG_WIDTH;
                else x = left;
                if (BOARD_FACE_LOW[i]) y = face_lo;
                else if (BOARD_FACE_HIGH[i]) y = face_hi;
                else if (BOARD_MID[i]) y = 96;
                else y = 128;
                z   = clamp_z(depth - 32);
                col = board_color;
            end
            exp_vertices.push_back({x[15:0], y[15:0], z[15:0]});
            exp_colors.push_back(col);
        end
    endfunction

    function automatic void log_error(input string line);
        $display("%s", line);
        error_count++;
        test_errors++;
    endfunction

    task automatic end_test(input string name);
        if (exp_vertices.size() != 0 || m_start || m_busy) begin
            log_error($sformatf("test %s ended while a shape was still being drawn", name));
        end
        test_count++;
        $display("test %s: %0d vertices checked, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    // lockstep model, inputs taken where the DUT samples them
    always @(posedge clk) begin
        live = 1'b1;
        emit = 1'b0;
        if (rst) begin
            m_start  = 1'b0;
            m_busy   = 1'b0;
            exp_done = 1'b0;
            exp_vertices.delete();
            exp_colors.delete();
        end else begin
            accept   = obstacle_valid && !m_busy && !m_start;
            exp_done = done_in && !m_busy && !m_start;
            if (m_busy) begin
                emit       = 1'b1;
                exp_vertex = exp_vertices.pop_front();
                exp_color  = exp_colors.pop_front();
                exp_tri    = (m_index % 3) == 0;
                m_index++;
                m_busy = exp_vertices.size() != 0;
            end else if (m_start) begin
                m_busy  = 1'b1;
                m_index = 0;
            end
            m_start = 1'b0;
            if (accept) begin
                cur_word = obstacle;
                build_reference(obstacle);
                m_start = exp_vertices.size() != 0;
            end
        end
    end

    // outputs settle half a cycle after the edge
    always @(negedge clk) begin
        if (live) begin
            if (done_out !== exp_done) begin
                log_error($sformatf("ERR done_out: got %h, expected %h", done_out, exp_done));
            end
            if (emit) begin
                if (new_triangle !== exp_tri) begin
                    log_error($sformatf("triangle strobe %s at vertex %0d of obstacle %h",
                        exp_tri ? "missing" : "unexpected", m_index - 1, cur_word));
                end
                if (vertex !== exp_vertex) begin
                    log_error($sformatf("ERR vertex: got %h, expected %h (obstacle %h, vertex %0d)",
                        vertex, exp_vertex, cur_word, m_index - 1));
                end
                if (color !== exp_color) begin
                    log_error($sformatf("ERR color: got %h, expected %h (obstacle %h, vertex %0d)",
                        color, exp_color, cur_word, m_index - 1));
                end
                check_count++;
                test_checks++;
            end else begin
                if (new_triangle !== 1'b0) begin
                    log_error("triangle strobe seen while no vertex was due");
                end
                if (vertex !== last_vertex || color !== last_color) begin
                    log_error("vertex or colour changed while no vertex was due");
                end
            end
        end
        last_vertex = vertex;
        last_color  = color;
    end

endmodule

//--- tb/tb_triangle_creator.sv
`timescale 1ns/1ps

module tb_triangle_creator;
    localparam int MIN_Z           = 8;
    localparam int PEG_WIDTH       = 10;
    localparam int RANDOM_WORDS    = 40;
    localparam int WORD_COUNT      = 34 + RANDOM_WORDS;
    localparam int CYCLES_PER_WORD = 40;
    localparam int CLOCK_NS        = 40;
    localparam int MARGIN_NS       = 400 * CLOCK_NS;

    logic        clk;
    logic        rst;
    logic [15:0] obstacle;
    logic        obstacle_valid;
    logic        done_in;
    logic [47:0] vertex;
    logic [15:0] color;
    logic        new_triangle;
    logic        done_out;
    int          seed;
    int          rnd;

    tb_clock i_tb_clock (
        .clk (clk),
        .rst (rst)
    );

    triangle_creator #(
        .MIN_Z     (MIN_Z),
        .PEG_WIDTH (PEG_WIDTH)
    ) i_triangle_creator (
        .clk            (clk),
        .rst            (rst),
        .obstacle       (obstacle),
        .obstacle_valid (obstacle_valid),
        .done_in        (done_in),
        .vertex         (vertex),
        .color          (color),
        .new_triangle   (new_triangle),
        .done_out       (done_out)
    );

    tb_checker #(
        .MIN_Z     (MIN_Z),
        .PEG_WIDTH (PEG_WIDTH)
    ) i_tb_checker (
        .clk            (clk),
        .rst            (rst),
        .obstacle       (obstacle),
        .obstacle_valid (obstacle_valid),
        .done_in        (done_in),
        .vertex         (vertex),
        .color          (color),
        .new_triangle   (new_triangle),
        .done_out       (done_out)
    );

    function automatic logic [15:0] make_word(input int kind, input int lane, input int depth);
        return {kind[2:0], lane[1:0], depth[10:0]};
    endfunction

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge clk);
    endtask

    task automatic pulse_word(input logic [15:0] word);
        @(negedge clk);
        obstacle       = word;
        obstacle_valid = 1'b1;
        @(negedge clk);
        obstacle_valid = 1'b0;
    endtask

    task automatic pulse_done();
        @(negedge clk);
        done_in = 1'b1;
        @(negedge clk);
        done_in = 1'b0;
    endtask

    // wait for the strobes to start and stop, then keep words 30 cycles apart
    task automatic settle(input bit drawn);
        int waited;
        int quiet;
        waited = 0;
        quiet  = 0;
        if (drawn) begin
            while (new_triangle !== 1'b1 && waited < 8) begin
                @(negedge clk);
                waited++;
            end
            while (quiet < 4 && waited < 40) begin
                @(negedge clk);
                waited++;
                quiet = new_triangle ? 0 : quiet + 1;
            end
        end
        while (waited < 30) begin
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic send_word(input logic [15:0] word);
        pulse_word(word);
        settle(i_tb_checker.shape_length(word) > 0);
    endtask

    initial begin
        obstacle       = '0;
        obstacle_valid = 1'b0;
        done_in        = 1'b0;
        seed           = 32'h90c5;
        rnd            = $urandom(seed);
        @(negedge rst);
        idle(2);

        for (int kind = 1; kind <= 4; kind++) begin
            for (int lane = 0; lane < 4; lane++) begin
                send_word(make_word(kind, lane, 1200 + 16 * lane));
            end
        end
        i_tb_checker.end_test("kinds and lanes");

        for (int kind = 1; kind <= 3; kind++) begin
            send_word(make_word(kind, 1, 39));  // one below the limit
            send_word(make_word(kind, 1, 40));
        end
        i_tb_checker.end_test("cull limit");

        send_word(make_word(4, 0, 100));
        send_word(make_word(4, 2, 135));
        i_tb_checker.end_test("car near clamp");

        send_word(make_word(0, 1, 900));
        send_word(make_word(5, 1, 900));
        send_word(make_word(6, 2, 900));
        send_word(make_word(7, 3, 900));
        // second word lands on the start cycle, the rest while busy
        @(negedge clk);
        obstacle       = make_word(4, 1, 700);
        obstacle_valid = 1'b1;
        @(negedge clk);
        obstacle       = make_word(2, 0, 600);
        @(negedge clk);
        obstacle_valid = 1'b0;
        idle(4);
        pulse_word(make_word(1, 0, 800));
        idle(3);
        pulse_word(make_word(6, 2, 500));
        settle(1'b1);
        i_tb_checker.end_test("ignored words");

        pulse_done();
        idle(2);
        pulse_done();
        @(negedge clk);
        obstacle       = make_word(3, 2, 300);
        obstacle_valid = 1'b1;
        done_in        = 1'b1;
        @(negedge clk);
        obstacle_valid = 1'b0;  // done still high on the start cycle
        @(negedge clk);
        done_in = 1'b0;
        idle(5);
        pulse_done();
        settle(1'b1);
        pulse_done();
        idle(3);
        i_tb_checker.end_test("done relay");

        for (int n = 0; n < RANDOM_WORDS; n++) begin
            send_word(make_word(1 + $urandom % 4, $urandom % 4, $urandom % 2048));
        end
        i_tb_checker.end_test("random words");

        idle(4);
        $display("%0d tests, %0d vertices checked, %0d errors", i_tb_checker.test_count,
            i_tb_checker.check_count, i_tb_checker.error_count);
        if (i_tb_checker.error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(WORD_COUNT * CYCLES_PER_WORD * CLOCK_NS + MARGIN_NS);
        $display("watchdog expired before the tests completed");
        $display("Testbench failed");
        $finish;
    end

endmodule

//--- flist.f
rtl/obstacle_pkg.sv
rtl/scene_pkg.sv
rtl/obstacle_decoder.sv
rtl/shape_table.sv
rtl/vertex_sequencer.sv
rtl/triangle_creator.sv
tb/tb_clock.sv
tb/tb_checker.sv
tb/tb_triangle_creator.sv
